// ==== rtl/fmaPkg.sv ====
////////////////////////////////////////
// FMA normalization shared definitions
// format constants, widths and vector types
////////////////////////////////////////

`default_nettype none

package fmaPkg;

    ////////////////////////////////////////
    // format constants
    ////////////////////////////////////////

    // wide format is single precision
    localparam int NF    = 23;
    localparam int NE    = 8;
    localparam int BIAS  = 127;

    // narrow format is half precision
    localparam int NF1   = 10;
    localparam int BIAS1 = 15;

    // fmt select encodings
    localparam logic FMTWIDE   = 1'b1;
    localparam logic FMTNARROW = 1'b0;

    ////////////////////////////////////////
    // derived widths
    ////////////////////////////////////////

    localparam int SUMLEN   = 3*NF + 6;
    // three guard zeros above the sum
    localparam int SHIFTLEN = 3*NF + 9;
    localparam int CNTLEN   = $clog2(3*NF + 7);
    // two extra bits for sign and overflow
    localparam int EXPLEN   = NE + 2;

    // denormal window limits in the wide bias
    localparam int WIDEDENMIN   = -(NF + 2);
    localparam int NARROWDENMAX = BIAS - BIAS1;
    localparam int NARROWDENMIN = -(NF1 + 2) + BIAS - BIAS1;

    // shared vector types
    typedef logic [SUMLEN-1:0]   sumT;
    typedef logic [SHIFTLEN-1:0] shiftT;
    typedef logic [CNTLEN-1:0]   cntT;
    typedef logic [EXPLEN-1:0]   expT;
    typedef logic [NE-1:0]       zeT;

endpackage

`default_nettype wire

// ==== rtl/normLzc.sv ====
////////////////////////////////////////
// leading zero counter over the FMA sum
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module normLzc (
    // positive sum magnitude
    input  fmaPkg::sumT sm,
    // zeros above the leading one
    output fmaPkg::cntT nCnt
);

    import fmaPkg::*;

    ////////////////////////////////////////
    // priority scan
    ////////////////////////////////////////

    // walk up from bit 0 so the highest set bit is the last to write
    // the count, which gives top-bit priority without a break
    always_comb begin
        nCnt = cntT'(SUMLEN);
        for (int i = 0; i < SUMLEN; i++) begin
            if (sm[i]) begin
                // distance from the msb of the sum
                nCnt = cntT'(SUMLEN - 1 - i);
            end
        end
    end

    // an all zero sum keeps the SUMLEN default
    // exact count here so no off by one fixup downstream

endmodule

`default_nettype wire

// ==== rtl/fmaShiftCalc.sv ====
////////////////////////////////////////
// FMA shift calculation
// sum exponent, format rebase, flags and shift amount
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fmaShiftCalc (
    input  fmaPkg::sumT   sm,
    // exponent of the addend
    input  fmaPkg::zeT    ze,
    // product exponent with the wide bias
    input  fmaPkg::expT   pe,
    input  fmaPkg::cntT   nCnt,
    input  logic          fmt,
    input  logic          killProd,
    input  logic          zDenorm,
    output fmaPkg::expT   normSumExp,
    output logic          smZero,
    output logic          preResultDenorm,
    output fmaPkg::cntT   shiftAmt,
    output fmaPkg::shiftT shiftIn
);

    import fmaPkg::*;

    // sum exponent in the wide bias, before rebasing
    expT rawExp;
    // rebased into the narrow bias
    expT narrowExp;
    // extra right shift for denormal results
    cntT denormShift;
    // window compares per format
    logic wideLez;
    logic wideGeMin;
    logic narrowLeMax;
    logic narrowGeMin;

    ////////////////////////////////////////
    // exponent
    ////////////////////////////////////////

    assign smZero = ~|sm;

    // killed product takes ze directly
    // a denormal ze has its lsb cleared since its true exponent is one
    // otherwise shift the product point over by the leading zeros
    assign rawExp = killProd ? {2'b00, ze[NE-1:1], ze[0] & ~zDenorm}
                             : pe - expT'(nCnt) - expT'(1) + expT'(NF + 4);

    // zero exponent must stay zero after the rebase
    assign narrowExp = (rawExp - expT'(BIAS) + expT'(BIAS1)) & {EXPLEN{|rawExp}};

    always_comb begin
        case (fmt)
            FMTWIDE:   normSumExp = rawExp;
            FMTNARROW: normSumExp = narrowExp;
        endcase
    end

    ////////////////////////////////////////
    // denormal detection
    ////////////////////////////////////////

    // wide window is raw <= 0 and raw >= -(NF+2)
    assign wideLez   = rawExp[EXPLEN-1] | ~|rawExp;
    assign wideGeMin = $signed(rawExp) >= $signed(expT'(WIDEDENMIN));

    // narrow window is the same range moved into the wide bias
    assign narrowLeMax = $signed(rawExp) <= $signed(expT'(NARROWDENMAX));
    // a raw zero also counts since the rebase holds it at zero
    assign narrowGeMin = ($signed(rawExp) >= $signed(expT'(NARROWDENMIN))) | ~|rawExp;

    always_comb begin
        case (fmt)
            FMTWIDE:   preResultDenorm = wideLez & wideGeMin & ~smZero;
            FMTNARROW: preResultDenorm = narrowLeMax & narrowGeMin & ~smZero;
        endcase
    end

    ////////////////////////////////////////
    // shift amount
    ////////////////////////////////////////

    // normal result shifts one more to drop the leading one
    // denormal takes the converted exponent bits instead
    assign denormShift = (preResultDenorm & ~killProd) ? normSumExp[CNTLEN-1:0]
                                                       : cntT'(1);

    // leading zero count does not apply when the product is killed
    assign shiftAmt = (nCnt & {CNTLEN{~killProd}}) + denormShift;

    // headroom above the sum for the shifter
    assign shiftIn = {3'b000, sm};

endmodule

`default_nettype wire

// ==== rtl/normShifter.sv ====
////////////////////////////////////////
// registered left barrel shifter
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module normShifter (
    input  logic          clk,
    input  logic          arstN,
    input  logic          valid,
    input  fmaPkg::shiftT shiftIn,
    input  fmaPkg::cntT   shiftAmt,
    output logic          shiftedValid,
    output fmaPkg::shiftT shifted
);

    import fmaPkg::*;

    // one entry per barrel level, entry 0 is the input
    shiftT stage [CNTLEN+1];

    assign stage[0] = shiftIn;

    ////////////////////////////////////////
    // log shifter
    ////////////////////////////////////////

    // level k moves by 2**k when that amount bit is set
    // bits pushed past the top are dropped
    for (genvar k = 0; k < CNTLEN; k++) begin : gLevel
        assign stage[k+1] = shiftAmt[k] ? (stage[k] << (2**k)) : stage[k];
    end

    // output register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shiftedValid <= 1'b0;
            shifted      <= '0;
        end else begin
            shiftedValid <= valid;
            // hold the last result between items
            if (valid) begin
                shifted <= stage[CNTLEN];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fmaNormalize.sv ====
////////////////////////////////////////
// FMA normalization front end
// two stage pipe over count, calc and shift
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fmaNormalize (
    input  logic          clk,
    input  logic          arstN,
    input  logic          inValid,
    input  fmaPkg::sumT   sm,
    input  fmaPkg::zeT    ze,
    input  fmaPkg::expT   pe,
    input  logic          fmt,
    input  logic          killProd,
    input  logic          zDenorm,
    output logic          outValid,
    output fmaPkg::expT   normSumExp,
    output logic          smZero,
    output logic          preResultDenorm,
    output fmaPkg::shiftT shifted
);

    import fmaPkg::*;

    // combinational results of stage 0
    cntT   nCnt;
    expT   calcExp;
    logic  calcZero;
    logic  calcDenorm;
    cntT   calcShiftAmt;
    shiftT calcShiftIn;

    // stage 1 registers
    logic  s1Valid;
    expT   s1Exp;
    logic  s1Zero;
    logic  s1Denorm;
    cntT   s1ShiftAmt;
    shiftT s1ShiftIn;

    ////////////////////////////////////////
    // stage 0 logic
    ////////////////////////////////////////

    normLzc uLzc (
        .sm   (sm),
        .nCnt (nCnt)
    );

    fmaShiftCalc uCalc (
        .sm              (sm),
        .ze              (ze),
        .pe              (pe),
        .nCnt            (nCnt),
        .fmt             (fmt),
        .killProd        (killProd),
        .zDenorm         (zDenorm),
        .normSumExp      (calcExp),
        .smZero          (calcZero),
        .preResultDenorm (calcDenorm),
        .shiftAmt        (calcShiftAmt),
        .shiftIn         (calcShiftIn)
    );

    // stage 1 capture, data only loads on a valid input
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid    <= 1'b0;
            s1Exp      <= '0;
            s1Zero     <= 1'b0;
            s1Denorm   <= 1'b0;
            s1ShiftAmt <= '0;
            s1ShiftIn  <= '0;
        end else begin
            s1Valid <= inValid;
            if (inValid) begin
                s1Exp      <= calcExp;
                s1Zero     <= calcZero;
                s1Denorm   <= calcDenorm;
                s1ShiftAmt <= calcShiftAmt;
                s1ShiftIn  <= calcShiftIn;
            end
        end
    end

    ////////////////////////////////////////
    // stage 2
    ////////////////////////////////////////

    // shifter owns the stage 2 valid
    normShifter uShift (
        .clk          (clk),
        .arstN        (arstN),
        .valid        (s1Valid),
        .shiftIn      (s1ShiftIn),
        .shiftAmt     (s1ShiftAmt),
        .shiftedValid (outValid),
        .shifted      (shifted)
    );

    // exponent and flags ride along with the shifter output
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            normSumExp      <= '0;
            smZero          <= 1'b0;
            preResultDenorm <= 1'b0;
        end else if (s1Valid) begin
            normSumExp      <= s1Exp;
            smZero          <= s1Zero;
            preResultDenorm <= s1Denorm;
        end
    end

endmodule

`default_nettype wire

// ==== test/fmaNormalizeChecks.svh ====
////////////////////////////////////////
// FMA normalize testbench checks
// compare tasks per result kind and the counters
////////////////////////////////////////

`ifndef FMA_NORMALIZE_CHECKS_SVH
`define FMA_NORMALIZE_CHECKS_SVH

// wrong values seen by the compare tasks
int checkErrors = 0;
// latency, stray outputs and leftovers
int otherErrors = 0;
int casesPassed = 0;
int casesFailed = 0;
// set by any failing compare of the current case
bit caseBad = 1'b0;

task automatic checkExp(input string name, input expT expected, input expT actual);
    if (actual !== expected) begin
        $display("ERR %s normSumExp expected %h actual %h", name, expected, actual);
        checkErrors++;
        caseBad = 1'b1;
    end
endtask

// flags are packed as {smZero, preResultDenorm}
task automatic checkFlags(input string name, input logic [1:0] expected,
                          input logic [1:0] actual);
    if (actual !== expected) begin
        $display("ERR %s flags expected %b actual %b", name, expected, actual);
        checkErrors++;
        caseBad = 1'b1;
    end
endtask

task automatic checkShift(input string name, input shiftT expected, input shiftT actual);
    if (actual !== expected) begin
        $display("ERR %s shifted expected %h actual %h", name, expected, actual);
        checkErrors++;
        caseBad = 1'b1;
    end
endtask

`endif

// ==== test/fmaNormalizeTb.sv ====
////////////////////////////////////////
// FMA normalize testbench
// file driven cases through the two stage pipe
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fmaNormalizeTb;

    import fmaPkg::*;

    // one line of the case file
    typedef struct {
        string name;
        sumT   sm;
        zeT    ze;
        expT   pe;
        logic  fmt;
        logic  killProd;
        logic  zDenorm;
        expT   exp;
        logic  zero;
        logic  denorm;
        shiftT shifted;
        int    idle;
    } caseT;

    logic  clk;
    logic  arstN;
    logic  inValid;
    sumT   sm;
    zeT    ze;
    expT   pe;
    logic  fmt;
    logic  killProd;
    logic  zDenorm;
    logic  outValid;
    expT   normSumExp;
    logic  smZero;
    logic  preResultDenorm;
    shiftT shifted;

    caseT cases [$];
    // in flight case indices and the cycle each one is due
    int pendIdx [$];
    int pendCycle [$];
    int cycleCount = 0;
    int cycleLimit = 0;
    bit limitSet = 1'b0;
    int doneCount = 0;
    int monIdx;
    int monDue;

    `include "fmaNormalizeChecks.svh"

    fmaNormalize dut (
        .clk             (clk),
        .arstN           (arstN),
        .inValid         (inValid),
        .sm              (sm),
        .ze              (ze),
        .pe              (pe),
        .fmt             (fmt),
        .killProd        (killProd),
        .zDenorm         (zDenorm),
        .outValid        (outValid),
        .normSumExp      (normSumExp),
        .smZero          (smZero),
        .preResultDenorm (preResultDenorm),
        .shifted         (shifted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    ////////////////////////////////////////
    // case file and driver
    ////////////////////////////////////////

    task automatic readCases(output bit ok);
        int    fd;
        int    got;
        string line;
        caseT  c;
        ok = 1'b1;
        fd = $fopen("test/fmaNormCases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file");
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            // blank and comment lines carry no case
            if (got <= 1 || line.substr(0, 0) == "#") begin
                continue;
            end
            got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %d", c.name, c.sm, c.ze,
                          c.pe, c.fmt, c.killProd, c.zDenorm, c.exp, c.zero, c.denorm,
                          c.shifted, c.idle);
            if (got != 12) begin
                $display("malformed case line: %s", line);
                ok = 1'b0;
            end else begin
                cases.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // junk on the data inputs proves they are ignored without inValid
    task automatic idleInputs();
        inValid  = 1'b0;
        sm       = '1;
        ze       = '1;
        pe       = '1;
        fmt      = ~fmt;
        killProd = 1'b1;
        zDenorm  = 1'b1;
    endtask

    task automatic runCases();
        repeat (4) @(posedge clk);
        #1;
        if (outValid !== 1'b0) begin
            $display("outValid is not low while reset is held");
            otherErrors++;
        end
        arstN = 1'b1;
        foreach (cases[i]) begin
            @(posedge clk);
            #1;
            inValid  = 1'b1;
            sm       = cases[i].sm;
            ze       = cases[i].ze;
            pe       = cases[i].pe;
            fmt      = cases[i].fmt;
            killProd = cases[i].killProd;
            zDenorm  = cases[i].zDenorm;
            pendIdx.push_back(i);
            pendCycle.push_back(cycleCount + 2);
            repeat (cases[i].idle) begin
                @(posedge clk);
                #1;
                idleInputs();
            end
        end
        @(posedge clk);
        #1;
        idleInputs();
        wait (doneCount == cases.size());
        // a few more cycles to catch stray outValid
        repeat (4) @(posedge clk);
    endtask

    ////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (arstN === 1'b1 && outValid === 1'b1) begin
            if (pendIdx.size() == 0) begin
                $display("outValid high at cycle %0d with no case in flight", cycleCount);
                otherErrors++;
            end else begin
                monIdx = pendIdx.pop_front();
                monDue = pendCycle.pop_front();
                caseBad = 1'b0;
                if (cycleCount != monDue) begin
                    $display("case %s came out at cycle %0d instead of cycle %0d",
                             cases[monIdx].name, cycleCount, monDue);
                    otherErrors++;
                    caseBad = 1'b1;
                end
                checkExp(cases[monIdx].name, cases[monIdx].exp, normSumExp);
                checkFlags(cases[monIdx].name, {cases[monIdx].zero, cases[monIdx].denorm},
                           {smZero, preResultDenorm});
                checkShift(cases[monIdx].name, cases[monIdx].shifted, shifted);
                if (caseBad) begin
                    casesFailed++;
                end else begin
                    casesPassed++;
                    $display("ok %s", cases[monIdx].name);
                end
                doneCount++;
            end
        end
    end

    // limit from case count and idle cycles, two cycles of latency per item
    initial begin
        wait (limitSet);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
        end
        $display("timeout at cycle %0d with %0d of %0d cases done and %0d still in flight",
                 cycleCount, doneCount, cases.size(), pendIdx.size());
        $display("TB FAILED");
        $finish;
    end

    initial begin
        bit readOk;
        int idleTotal;
        arstN    = 1'b0;
        inValid  = 1'b0;
        sm       = '0;
        ze       = '0;
        pe       = '0;
        fmt      = 1'b0;
        killProd = 1'b0;
        zDenorm  = 1'b0;
        readCases(readOk);
        if (!readOk || cases.size() == 0) begin
            $display("no usable cases in the case file");
            $display("TB FAILED");
            $finish;
        end else begin
            idleTotal = 0;
            foreach (cases[i]) begin
                idleTotal += cases[i].idle;
            end
            cycleLimit = (cases.size() + idleTotal + 2) * 2 + 20;
            limitSet = 1'b1;
            runCases();
            $display("cases %0d passed %0d failed %0d other errors %0d",
                     cases.size(), casesPassed, casesFailed, otherErrors);
            if (checkErrors == 0 && otherErrors == 0 && casesPassed == cases.size()) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== fmaNormalize.f ====
+incdir+test
rtl/fmaPkg.sv
rtl/normLzc.sv
rtl/fmaShiftCalc.sv
rtl/normShifter.sv
rtl/fmaNormalize.sv
test/fmaNormalizeTb.sv

// ==== Makefile ====
TOP = fmaNormalizeTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal -f fmaNormalize.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// ==== test/fmaNormCases.txt ====
# name sm ze pe fmt killProd zDenorm | normSumExp smZero preResultDenorm shifted | idle
# all fields hex except idle, the count of idle cycles after the case
wNormTop     4400000000000000000 00 064 1 0 0 07e 0 0 08800000000000000000 0
wNormMid     0000004400000000000 00 050 1 0 0 052 0 0 08800000000000000000 0
wNormLow     0000000000000000abc 00 040 1 0 0 01b 0 0 0abc0000000000000000 2
nNormTop     4400000000000000000 00 064 0 0 0 00e 0 0 08800000000000000000 0
nUnderMid    0000004400000000000 00 050 0 0 0 3e2 0 0 08800000000000000000 0
nRawZero     4400000000000000000 00 3e6 0 0 0 000 0 1 04400000000000000000 0
wRawZero     4400000000000000000 00 3e6 1 0 0 000 0 1 04400000000000000000 1
wDenIn       0000000110000000000 00 3eb 1 0 0 3e7 0 1 00000002200000000000 0
wDenOut      0000000110000000000 00 3ea 1 0 0 3e6 0 0 08800000000000000000 0
wRawOne      0000000110000000000 00 005 1 0 0 001 0 0 08800000000000000000 0
nDenLow      0000000110000000000 00 068 0 0 0 3f4 0 1 00004400000000000000 0
nDenBelow    0000000110000000000 00 067 0 0 0 3f3 0 0 08800000000000000000 0
nDenTop      0000000110000000000 00 074 0 0 0 000 0 1 04400000000000000000 0
nDenAbove    0000000110000000000 00 075 0 0 0 001 0 0 08800000000000000000 3
kWide        0000004400000000000 85 123 1 1 0 085 0 0 00000008800000000000 0
kWideDen     0000004400000000000 01 123 1 1 1 000 0 1 00000008800000000000 0
kNarrow      0000004400000000000 71 123 0 1 0 001 0 0 00000008800000000000 0
kNarrowDen   0000004400000000000 6b 123 0 1 1 3fa 0 1 00000008800000000000 0
zWide        0000000000000000000 00 050 1 0 0 01f 1 0 00000000000000000000 0
zNarrow      0000000000000000000 00 095 0 0 0 3f4 1 0 00000000000000000000 0
zWideRawZero 0000000000000000000 00 031 1 0 0 000 1 0 00000000000000000000 0
zKilled      0000000000000000000 40 000 0 1 0 3d0 1 0 00000000000000000000 0
